// File: include/book_consts.svh
// Order book sizing constants
// Levels per book, product count and field widths
`ifndef BOOK_CONSTS_SVH
`define BOOK_CONSTS_SVH

// Price levels held per book, level 0 is best
`define BOOK_ENTRIES_N 4

// Products in the state table
`define BOOK_PRODUCTS_N 8

// Product id, wide enough for BOOK_PRODUCTS_N
`define BOOK_ID_W 3

// Price key
`define BOOK_KEY_W 16

// Volume per level
`define BOOK_VOLUME_W 16

`endif

// File: hdl/book_pkg.sv
// Order book types
// Field types, update command encoding and one product's book state
`include "book_consts.svh"

package book_pkg;

  // Product index into the state table
  typedef logic [`BOOK_ID_W-1:0] id_t;

  // Price, compared unsigned
  typedef logic [`BOOK_KEY_W-1:0] key_t;

  // Volume at one price level
  typedef logic [`BOOK_VOLUME_W-1:0] volume_t;

  // Update commands
  typedef enum logic [1:0] {
    CMD_NOP    = 2'd0,
    CMD_ADD    = 2'd1,
    CMD_DELETE = 2'd2,
    CMD_CLEAR  = 2'd3
  } cmd_e;

  // One side of a book
  // Valid levels contiguous from level 0, keys strictly descending
  typedef struct packed {
    logic [`BOOK_ENTRIES_N-1:0]    vld;
    key_t [`BOOK_ENTRIES_N-1:0]    key;
    volume_t [`BOOK_ENTRIES_N-1:0] volume;
  } book_state_t;

endpackage

// File: hdl/book_stage_if.sv
// Pipeline stage bus for one update
// Valid plus the update fields, src and dst modports
`timescale 1ns/1ns

interface book_stage_if;

  // Stage holds an item this cycle
  logic                vld;
  // Update fields
  book_pkg::id_t       prod_id;
  book_pkg::cmd_e      cmd;
  book_pkg::key_t      key;
  book_pkg::volume_t   volume;

  // Driving stage
  modport src (
    output vld, prod_id, cmd, key, volume
  );

  // Sampling stage
  modport dst (
    input vld, prod_id, cmd, key, volume
  );

endinterface

// File: hdl/upd_intake.sv
// Update pipeline stage S1
// Update bus register, state table read request
// Collision latch against a pending writeback to the same product
`timescale 1ns/1ns

module upd_intake (
  input  logic                  clk
, input  logic                  rst
, input  logic                  i_upd_vld
, input  book_pkg::id_t         i_upd_prod_id
, input  book_pkg::cmd_e        i_upd_cmd
, input  book_pkg::key_t        i_upd_key
, input  book_pkg::volume_t     i_upd_volume
, input  logic                  i_wrbk_vld
, input  book_pkg::id_t         i_wrbk_prod_id
, input  book_pkg::book_state_t i_wrbk_state
, output logic                  o_ren
, output book_pkg::id_t         o_raddr
, output logic                  o_coll_vld
, output book_pkg::book_state_t o_coll_state
, book_stage_if.src             s1
);
  import book_pkg::*;

  logic    s1_vld_r;
  id_t     s1_prod_id_r;
  cmd_e    s1_cmd_r;
  key_t    s1_key_r;
  volume_t s1_volume_r;
  logic    coll;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld_r <= 1'b0;
    end else begin
      s1_vld_r <= i_upd_vld;
    end
  end

  // Update fields, loaded only with a valid update
  always_ff @(posedge clk) begin
    if (i_upd_vld) begin
      s1_prod_id_r <= i_upd_prod_id;
      s1_cmd_r     <= i_upd_cmd;
      s1_key_r     <= i_upd_key;
      s1_volume_r  <= i_upd_volume;
    end
  end

  // Writeback to this product lands on the same edge as the read
  // Kill the read and hand the writeback state to S2 instead
  assign coll         = s1_vld_r & i_wrbk_vld & (i_wrbk_prod_id == s1_prod_id_r);
  assign o_coll_vld   = coll;
  assign o_coll_state = i_wrbk_state;

  assign o_ren   = s1_vld_r & ~coll;
  assign o_raddr = s1_prod_id_r;

  assign s1.vld     = s1_vld_r;
  assign s1.prod_id = s1_prod_id_r;
  assign s1.cmd     = s1_cmd_r;
  assign s1.key     = s1_key_r;
  assign s1.volume  = s1_volume_r;

  // Colliding writeback is the update taken three edges before S1's
  a_coll_age: assert property (@(posedge clk) disable iff (rst)
    o_coll_vld |-> $past(i_upd_vld, 4) && ($past(i_upd_prod_id, 4) == s1_prod_id_r));

endmodule

// File: hdl/state_table.sv
// Book state memory, one word per product
// Synchronous read, write from the writeback register
// Per-product written bits so untouched books read as empty
`timescale 1ns/1ns

module state_table #(
  parameter int DEPTH = 8
, parameter int W     = 132
) (
  input  logic                     clk
, input  logic                     rst
, input  logic                     i_ren
, input  logic [$clog2(DEPTH)-1:0] i_raddr
, input  logic                     i_wen
, input  logic [$clog2(DEPTH)-1:0] i_waddr
, input  logic [W-1:0]             i_wdata
, output logic [W-1:0]             o_rdata
);

  logic [W-1:0]     mem [DEPTH];
  logic [DEPTH-1:0] written_r;
  logic [W-1:0]     rdata_r;

  // Product has been written since reset
  always_ff @(posedge clk) begin
    if (rst) begin
      written_r <= '0;
    end else if (i_wen) begin
      written_r[i_waddr] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Data valid the cycle after the request
  always_ff @(posedge clk) begin
    if (i_ren) begin
      rdata_r <= written_r[i_raddr] ? mem[i_raddr] : '0;
    end
  end

  assign o_rdata = rdata_r;

endmodule

// File: hdl/book_forward.sv
// Update pipeline stages S2 and S3
// S2 register with the latched collision state
// Youngest-first forwarding of in-flight book state
// S3 register with the selected book
`timescale 1ns/1ns

module book_forward (
  input  logic                  clk
, input  logic                  rst
, book_stage_if.dst             s1
, input  logic                  i_coll_vld
, input  book_pkg::book_state_t i_coll_state
, input  book_pkg::book_state_t i_rdata
, input  book_pkg::book_state_t i_s3_next_state
, input  logic                  i_wrbk_vld
, input  book_pkg::id_t         i_wrbk_prod_id
, input  book_pkg::book_state_t i_wrbk_state
, book_stage_if.src             s3
, output book_pkg::book_state_t o_s3_state
);
  import book_pkg::*;

  // S2
  logic        s2_vld_r;
  id_t         s2_prod_id_r;
  cmd_e        s2_cmd_r;
  key_t        s2_key_r;
  volume_t     s2_volume_r;
  logic        s2_coll_vld_r;
  book_state_t s2_coll_state_r;
  logic        s2_hit_s3;
  logic        s2_hit_wrbk;
  // One-hot pick: S3 next, writeback, collision, table
  logic [3:0]  s2_sel;
  book_state_t s2_state;

  // S3
  logic        s3_vld_r;
  id_t         s3_prod_id_r;
  cmd_e        s3_cmd_r;
  key_t        s3_key_r;
  volume_t     s3_volume_r;
  book_state_t s3_state_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_vld_r <= 1'b0;
    end else begin
      s2_vld_r <= s1.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (s1.vld) begin
      s2_prod_id_r    <= s1.prod_id;
      s2_cmd_r        <= s1.cmd;
      s2_key_r        <= s1.key;
      s2_volume_r     <= s1.volume;
      // Table read was killed, keep the colliding state
      s2_coll_vld_r   <= i_coll_vld;
      s2_coll_state_r <= i_coll_state;
    end
  end

  // Same product further down the pipe
  assign s2_hit_s3   = s3_vld_r & (s3_prod_id_r == s2_prod_id_r);
  assign s2_hit_wrbk = i_wrbk_vld & (i_wrbk_prod_id == s2_prod_id_r);

  // Youngest state wins
  assign s2_sel[0] = s2_hit_s3;
  assign s2_sel[1] = ~s2_hit_s3 & s2_hit_wrbk;
  assign s2_sel[2] = ~s2_hit_s3 & ~s2_hit_wrbk & s2_coll_vld_r;
  assign s2_sel[3] = ~s2_hit_s3 & ~s2_hit_wrbk & ~s2_coll_vld_r;

  // Table data last, it arrives late in the cycle
  always_comb begin
    case (1'b1)
      s2_sel[0]: s2_state = i_s3_next_state;
      s2_sel[1]: s2_state = i_wrbk_state;
      s2_sel[2]: s2_state = s2_coll_state_r;
      default:   s2_state = i_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s3_vld_r <= 1'b0;
    end else begin
      s3_vld_r <= s2_vld_r;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_vld_r) begin
      s3_prod_id_r <= s2_prod_id_r;
      s3_cmd_r     <= s2_cmd_r;
      s3_key_r     <= s2_key_r;
      s3_volume_r  <= s2_volume_r;
      s3_state_r   <= s2_state;
    end
  end

  assign s3.vld     = s3_vld_r;
  assign s3.prod_id = s3_prod_id_r;
  assign s3.cmd     = s3_cmd_r;
  assign s3.key     = s3_key_r;
  assign s3.volume  = s3_volume_r;
  assign o_s3_state = s3_state_r;

  // Table data only taken when no write hit that word on the read edge
  a_table_fresh: assert property (@(posedge clk) disable iff (rst)
    s2_vld_r && s2_sel[3] |-> !$past(i_wrbk_vld && (i_wrbk_prod_id == s1.prod_id)));

endmodule

// File: hdl/book_exe.sv
// Update execute, combinational on the S3 item
// ADD, DELETE and CLEAR on one sorted book
// Level-0 change detect and new level-0 report
`timescale 1ns/1ns
`include "book_consts.svh"

module book_exe (
  book_stage_if.dst             s3
, input  book_pkg::book_state_t i_state
, output book_pkg::book_state_t o_next_state
, output logic                  o_lv0_changed
, output book_pkg::key_t        o_lv0_key
, output book_pkg::volume_t     o_lv0_volume
);
  import book_pkg::*;

  localparam int E = `BOOK_ENTRIES_N;

  logic [E-1:0] hit;
  logic [E-1:0] gt;
  logic [E-1:0] ins;
  logic         any_hit;
  book_state_t  dn_state;
  book_state_t  up_state;
  book_state_t  add_state;
  book_state_t  del_state;

  // Valid bits contiguous from level 0 and keys strictly descending
  function automatic logic well_formed(book_state_t st);
    logic         ok;
    logic [E-1:0] vld_inc;
    vld_inc = st.vld + 1'b1;
    ok      = ((st.vld & vld_inc) == '0);
    for (int i = 1; i < E; i++) begin
      if (st.vld[i] && !(st.key[i-1] > st.key[i])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // Per-level compare against the update key
  always_comb begin
    for (int i = 0; i < E; i++) begin
      hit[i] = i_state.vld[i] && (i_state.key[i] == s3.key);
      gt[i]  = i_state.vld[i] && (i_state.key[i] > s3.key);
    end
  end

  assign any_hit = |hit;

  // First level not above the new key, none if a full book beats it
  assign ins = ~gt & {gt[E-2:0], 1'b1};

  // Book moved one level down and one level up
  always_comb begin
    dn_state.vld    = i_state.vld << 1;
    dn_state.key    = i_state.key << `BOOK_KEY_W;
    dn_state.volume = i_state.volume << `BOOK_VOLUME_W;
    up_state.vld    = i_state.vld >> 1;
    up_state.key    = i_state.key >> `BOOK_KEY_W;
    up_state.volume = i_state.volume >> `BOOK_VOLUME_W;
  end

  // ADD
  always_comb begin
    add_state = i_state;
    for (int i = 0; i < E; i++) begin
      if (any_hit) begin
        // Key present, accumulate
        if (hit[i]) begin
          add_state.volume[i] = i_state.volume[i] + s3.volume;
        end
      end else if (ins[i]) begin
        add_state.vld[i]    = 1'b1;
        add_state.key[i]    = s3.key;
        add_state.volume[i] = s3.volume;
      end else if (!gt[i]) begin
        // Below the new level, lowest level drops off
        add_state.vld[i]    = dn_state.vld[i];
        add_state.key[i]    = dn_state.key[i];
        add_state.volume[i] = dn_state.volume[i];
      end
    end
  end

  // DELETE
  always_comb begin : del_blk
    logic shift;
    del_state = i_state;
    shift     = 1'b0;
    for (int i = 0; i < E; i++) begin
      if (hit[i]) begin
        if (i_state.volume[i] > s3.volume) begin
          del_state.volume[i] = i_state.volume[i] - s3.volume;
        end else begin
          shift = 1'b1;
        end
      end
      // Removed level and all below move up
      if (shift) begin
        del_state.vld[i]    = up_state.vld[i];
        del_state.key[i]    = up_state.key[i];
        del_state.volume[i] = up_state.volume[i];
      end
    end
  end

  always_comb begin
    case (s3.cmd)
      CMD_ADD:    o_next_state = add_state;
      CMD_DELETE: o_next_state = del_state;
      CMD_CLEAR:  o_next_state = '0;
      default:    o_next_state = i_state;
    endcase
  end

  // Level 0 appears, vanishes, or changes key or volume
  assign o_lv0_changed = (o_next_state.vld[0] != i_state.vld[0]) ||
                         (o_next_state.vld[0] &&
                          ((o_next_state.key[0] != i_state.key[0]) ||
                           (o_next_state.volume[0] != i_state.volume[0])));

  // Empty book reports zero
  assign o_lv0_key    = o_next_state.vld[0] ? o_next_state.key[0] : '0;
  assign o_lv0_volume = o_next_state.vld[0] ? o_next_state.volume[0] : '0;

  // Holds only if every book written back so far was well formed
  a_next_well_formed: assert final (!s3.vld || well_formed(o_next_state))
    else $error("book_exe: next book state not sorted or not contiguous");

endmodule

// File: hdl/book_writeback.sv
// Writeback and notify registers
// Writeback for every valid S3 item, notify on a level-0 change
`timescale 1ns/1ns

module book_writeback (
  input  logic                  clk
, input  logic                  rst
, book_stage_if.dst             s3
, input  book_pkg::book_state_t i_next_state
, input  logic                  i_lv0_changed
, input  book_pkg::key_t        i_lv0_key
, input  book_pkg::volume_t     i_lv0_volume
, output logic                  o_wrbk_vld
, output book_pkg::id_t         o_wrbk_prod_id
, output book_pkg::book_state_t o_wrbk_state
, output logic                  o_lv0_vld
, output book_pkg::id_t         o_lv0_prod_id
, output book_pkg::key_t        o_lv0_key
, output book_pkg::volume_t     o_lv0_volume
);
  import book_pkg::*;

  logic        wrbk_vld_r;
  id_t         wrbk_prod_id_r;
  book_state_t wrbk_state_r;
  logic        lv0_en;
  logic        lv0_vld_r;
  id_t         lv0_prod_id_r;
  key_t        lv0_key_r;
  volume_t     lv0_volume_r;

  assign lv0_en = s3.vld & i_lv0_changed;

  always_ff @(posedge clk) begin
    if (rst) begin
      wrbk_vld_r <= 1'b0;
      lv0_vld_r  <= 1'b0;
    end else begin
      wrbk_vld_r <= s3.vld;
      lv0_vld_r  <= lv0_en;
    end
  end

  // Book goes back to the table next edge
  always_ff @(posedge clk) begin
    if (s3.vld) begin
      wrbk_prod_id_r <= s3.prod_id;
      wrbk_state_r   <= i_next_state;
    end
  end

  // Notify payload holds until the next change
  always_ff @(posedge clk) begin
    if (lv0_en) begin
      lv0_prod_id_r <= s3.prod_id;
      lv0_key_r     <= i_lv0_key;
      lv0_volume_r  <= i_lv0_volume;
    end
  end

  assign o_wrbk_vld     = wrbk_vld_r;
  assign o_wrbk_prod_id = wrbk_prod_id_r;
  assign o_wrbk_state   = wrbk_state_r;

  assign o_lv0_vld     = lv0_vld_r;
  assign o_lv0_prod_id = lv0_prod_id_r;
  assign o_lv0_key     = lv0_key_r;
  assign o_lv0_volume  = lv0_volume_r;

endmodule

// File: hdl/book_update_top.sv
// Order book update pipeline, top level
// Intake, state table, forwarding, execute and writeback stages
// Update bus in, level-0 notify bus out
`timescale 1ns/1ns
`include "book_consts.svh"

module book_update_top (
  input  logic              clk
, input  logic              rst
, input  logic              i_upd_vld
, input  book_pkg::id_t     i_upd_prod_id
, input  book_pkg::cmd_e    i_upd_cmd
, input  book_pkg::key_t    i_upd_key
, input  book_pkg::volume_t i_upd_volume
, output logic              o_lv0_vld
, output book_pkg::id_t     o_lv0_prod_id
, output book_pkg::key_t    o_lv0_key
, output book_pkg::volume_t o_lv0_volume
);
  import book_pkg::*;

  // State table read
  logic        ren;
  id_t         raddr;
  book_state_t rdata;
  // Collision from S1
  logic        coll_vld;
  book_state_t coll_state;
  // S3 execute
  book_state_t s3_state;
  book_state_t next_state;
  logic        lv0_changed;
  key_t        lv0_key;
  volume_t     lv0_volume;
  // Writeback bus
  logic        wrbk_vld;
  id_t         wrbk_prod_id;
  book_state_t wrbk_state;

  book_stage_if s1_if ();
  book_stage_if s3_if ();

  upd_intake u_upd_intake (
    .clk            (clk)
  , .rst            (rst)
  , .i_upd_vld      (i_upd_vld)
  , .i_upd_prod_id  (i_upd_prod_id)
  , .i_upd_cmd      (i_upd_cmd)
  , .i_upd_key      (i_upd_key)
  , .i_upd_volume   (i_upd_volume)
  , .i_wrbk_vld     (wrbk_vld)
  , .i_wrbk_prod_id (wrbk_prod_id)
  , .i_wrbk_state   (wrbk_state)
  , .o_ren          (ren)
  , .o_raddr        (raddr)
  , .o_coll_vld     (coll_vld)
  , .o_coll_state   (coll_state)
  , .s1             (s1_if.src)
  );

  state_table #(
    .DEPTH (`BOOK_PRODUCTS_N)
  , .W     ($bits(book_state_t))
  ) u_state_table (
    .clk     (clk)
  , .rst     (rst)
  , .i_ren   (ren)
  , .i_raddr (raddr)
  , .i_wen   (wrbk_vld)
  , .i_waddr (wrbk_prod_id)
  , .i_wdata (wrbk_state)
  , .o_rdata (rdata)
  );

  book_forward u_book_forward (
    .clk             (clk)
  , .rst             (rst)
  , .s1              (s1_if.dst)
  , .i_coll_vld      (coll_vld)
  , .i_coll_state    (coll_state)
  , .i_rdata         (rdata)
  , .i_s3_next_state (next_state)
  , .i_wrbk_vld      (wrbk_vld)
  , .i_wrbk_prod_id  (wrbk_prod_id)
  , .i_wrbk_state    (wrbk_state)
  , .s3              (s3_if.src)
  , .o_s3_state      (s3_state)
  );

  book_exe u_book_exe (
    .s3            (s3_if.dst)
  , .i_state       (s3_state)
  , .o_next_state  (next_state)
  , .o_lv0_changed (lv0_changed)
  , .o_lv0_key     (lv0_key)
  , .o_lv0_volume  (lv0_volume)
  );

  book_writeback u_book_writeback (
    .clk            (clk)
  , .rst            (rst)
  , .s3             (s3_if.dst)
  , .i_next_state   (next_state)
  , .i_lv0_changed  (lv0_changed)
  , .i_lv0_key      (lv0_key)
  , .i_lv0_volume   (lv0_volume)
  , .o_wrbk_vld     (wrbk_vld)
  , .o_wrbk_prod_id (wrbk_prod_id)
  , .o_wrbk_state   (wrbk_state)
  , .o_lv0_vld      (o_lv0_vld)
  , .o_lv0_prod_id  (o_lv0_prod_id)
  , .o_lv0_key      (o_lv0_key)
  , .o_lv0_volume   (o_lv0_volume)
  );

endmodule

// File: verification/tb_clkgen.sv
// Clock and reset generator for the testbench
// 40 ns clock, reset held over the first 4 rising edges
`timescale 1ns/1ns

module tb_clkgen (
  output logic o_clk
, output logic o_rst
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 4;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

// File: verification/tb_book_update.sv
// Testbench for the order book update pipeline
// Reference book model, directed and random update streams
// Concurrent assertions check the level-0 notify bus
`timescale 1ns/1ns
`include "book_consts.svh"

module tb_book_update;
  import book_pkg::*;

  localparam int E               = `BOOK_ENTRIES_N;
  localparam int P               = `BOOK_PRODUCTS_N;
  localparam int RAND_CYCLES     = 200;
  localparam int DRAIN           = 6;
  localparam int N_TESTS         = 6;
  // Upper bound on directed updates plus their idle gaps
  localparam int DIRECTED_CYCLES = 120;
  localparam int STIM_CYCLES     = 4 + DIRECTED_CYCLES + RAND_CYCLES + N_TESTS * DRAIN;
  localparam int CYCLE_LIMIT     = 2 * STIM_CYCLES + 20;

  logic    clk;
  logic    rst;
  logic    rst_d;
  logic    upd_vld;
  id_t     upd_prod_id;
  cmd_e    upd_cmd;
  key_t    upd_key;
  volume_t upd_volume;
  logic    lv0_vld;
  id_t     lv0_prod_id;
  key_t    lv0_key;
  volume_t lv0_volume;

  // Reference books, level 0 first, m_cnt levels in use
  key_t    m_key [P][E];
  volume_t m_vol [P][E];
  int      m_cnt [P];

  // Expected notify of the update driven this cycle
  logic    exp_in_vld;
  id_t     exp_in_prod;
  key_t    exp_in_key;
  volume_t exp_in_vol;
  // Shifted each edge, index 4 lines up with o_lv0
  logic    exp_vld  [1:4];
  id_t     exp_prod [1:4];
  key_t    exp_key  [1:4];
  volume_t exp_vol  [1:4];

  string   cur_test;
  int      err_cnt;
  int      test_err0;
  int      tests_run;
  int      tests_failed;

  tb_clkgen u_clkgen (
    .o_clk (clk)
  , .o_rst (rst)
  );

  book_update_top UUT (
    .clk           (clk)
  , .rst           (rst)
  , .i_upd_vld     (upd_vld)
  , .i_upd_prod_id (upd_prod_id)
  , .i_upd_cmd     (upd_cmd)
  , .i_upd_key     (upd_key)
  , .i_upd_volume  (upd_volume)
  , .o_lv0_vld     (lv0_vld)
  , .o_lv0_prod_id (lv0_prod_id)
  , .o_lv0_key     (lv0_key)
  , .o_lv0_volume  (lv0_volume)
  );

  always @(posedge clk) begin
    rst_d       <= rst;
    exp_vld[1]  <= exp_in_vld;
    exp_prod[1] <= exp_in_prod;
    exp_key[1]  <= exp_in_key;
    exp_vol[1]  <= exp_in_vol;
    for (int i = 2; i <= 4; i++) begin
      exp_vld[i]  <= exp_vld[i-1];
      exp_prod[i] <= exp_prod[i-1];
      exp_key[i]  <= exp_key[i-1];
      exp_vol[i]  <= exp_vol[i-1];
    end
  end

  // No notify while reset is held
  a_quiet_in_reset: assert property (@(posedge clk) rst_d |-> !lv0_vld)
    else begin
      err_cnt++;
      $display("Notify valid seen during reset in test %s", cur_test);
    end

  // Notify present exactly when the model expects one
  a_lv0_vld: assert property (@(posedge clk) disable iff (rst) lv0_vld == exp_vld[4])
    else begin
      err_cnt++;
      $display("[FAIL] %s o_lv0_vld expected %0b actual %0b",
               cur_test, $sampled(exp_vld[4]), $sampled(lv0_vld));
    end

  a_lv0_data: assert property (@(posedge clk) disable iff (rst)
      exp_vld[4] |-> (lv0_prod_id == exp_prod[4] && lv0_key == exp_key[4] &&
                      lv0_volume == exp_vol[4]))
    else begin
      err_cnt++;
      $display("[FAIL] %s o_lv0 prod/key/volume expected %0d/%0d/%0d actual %0d/%0d/%0d",
               cur_test, $sampled(exp_prod[4]), $sampled(exp_key[4]), $sampled(exp_vol[4]),
               $sampled(lv0_prod_id), $sampled(lv0_key), $sampled(lv0_volume));
    end

  // Apply one update to the model and derive its notify
  task automatic apply_model(input id_t p, input cmd_e c, input key_t k, input volume_t v);
    int      pos;
    int      hit_i;
    logic    had0;
    logic    now0;
    key_t    old_k;
    volume_t old_v;
    had0  = (m_cnt[p] > 0);
    old_k = m_key[p][0];
    old_v = m_vol[p][0];
    hit_i = -1;
    for (int i = 0; i < m_cnt[p]; i++) begin
      if (m_key[p][i] == k) begin
        hit_i = i;
      end
    end
    if (c == CMD_ADD && hit_i >= 0) begin
      m_vol[p][hit_i] = m_vol[p][hit_i] + v;
    end else if (c == CMD_ADD) begin
      // First level with a lower key, or the end of the book
      pos = m_cnt[p];
      for (int i = m_cnt[p] - 1; i >= 0; i--) begin
        if (m_key[p][i] < k) begin
          pos = i;
        end
      end
      if (pos < E) begin
        for (int i = E - 1; i > pos; i--) begin
          m_key[p][i] = m_key[p][i-1];
          m_vol[p][i] = m_vol[p][i-1];
        end
        m_key[p][pos] = k;
        m_vol[p][pos] = v;
        if (m_cnt[p] < E) begin
          m_cnt[p]++;
        end
      end
    end else if (c == CMD_DELETE && hit_i >= 0) begin
      if (m_vol[p][hit_i] > v) begin
        m_vol[p][hit_i] = m_vol[p][hit_i] - v;
      end else begin
        for (int i = hit_i; i < m_cnt[p] - 1; i++) begin
          m_key[p][i] = m_key[p][i+1];
          m_vol[p][i] = m_vol[p][i+1];
        end
        m_cnt[p]--;
      end
    end else if (c == CMD_CLEAR) begin
      m_cnt[p] = 0;
    end
    now0        = (m_cnt[p] > 0);
    exp_in_vld  = (had0 != now0) ||
                  (now0 && (m_key[p][0] != old_k || m_vol[p][0] != old_v));
    exp_in_prod = p;
    exp_in_key  = now0 ? m_key[p][0] : '0;
    exp_in_vol  = now0 ? m_vol[p][0] : '0;
  endtask

  task automatic send(input id_t p, input cmd_e c, input key_t k, input volume_t v);
    @(negedge clk);
    upd_vld     = 1'b1;
    upd_prod_id = p;
    upd_cmd     = c;
    upd_key     = k;
    upd_volume  = v;
    apply_model(p, c, k, v);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      upd_vld    = 1'b0;
      exp_in_vld = 1'b0;
    end
  endtask

  // Update followed by two idle cycles, book goes through the table
  task automatic send_spaced(input id_t p, input cmd_e c, input key_t k, input volume_t v);
    send(p, c, k, v);
    idle(2);
  endtask

  // Mostly ADD, some DELETE, rare CLEAR
  task automatic send_random;
    int      r;
    id_t     p;
    cmd_e    c;
    key_t    k;
    volume_t v;
    r = $urandom_range(9);
    c = (r < 6) ? CMD_ADD : ((r < 9) ? CMD_DELETE : CMD_CLEAR);
    p = id_t'(4 + $urandom_range(1));
    k = key_t'(100 + 10 * $urandom_range(7));
    v = volume_t'(1 + $urandom_range(19));
    send(p, c, k, v);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
  endtask

  // Let the last notify reach the checks, then report
  task automatic end_test;
    idle(DRAIN);
    tests_run++;
    if (err_cnt == test_err0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, err_cnt - test_err0);
    end
  endtask

  initial begin
    upd_vld      = 1'b0;
    upd_prod_id  = '0;
    upd_cmd      = CMD_NOP;
    upd_key      = '0;
    upd_volume   = '0;
    exp_in_vld   = 1'b0;
    exp_in_prod  = '0;
    exp_in_key   = '0;
    exp_in_vol   = '0;
    rst_d        = 1'b0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "reset";
    for (int i = 1; i <= 4; i++) begin
      exp_vld[i] = 1'b0;
    end
    for (int i = 0; i < P; i++) begin
      m_cnt[i] = 0;
    end
    void'($urandom(5));
    wait (rst == 1'b0);

    start_test("reset_idle");
    idle(4);
    send(3'd7, CMD_ADD, 16'd300, 16'd12);
    end_test();

    start_test("add_empty");
    send(3'd0, CMD_ADD, 16'd1000, 16'd25);
    end_test();

    // Fill to four levels, a lower key then falls off
    start_test("add_levels");
    send_spaced(3'd1, CMD_ADD, 16'd500, 16'd10);
    send_spaced(3'd1, CMD_ADD, 16'd400, 16'd5);
    send_spaced(3'd1, CMD_ADD, 16'd500, 16'd7);
    send_spaced(3'd1, CMD_ADD, 16'd450, 16'd3);
    send_spaced(3'd1, CMD_ADD, 16'd300, 16'd2);
    send_spaced(3'd1, CMD_ADD, 16'd200, 16'd9);
    send_spaced(3'd1, CMD_DELETE, 16'd500, 16'd17);
    send_spaced(3'd1, CMD_DELETE, 16'd450, 16'd3);
    send_spaced(3'd1, CMD_DELETE, 16'd400, 16'd5);
    send_spaced(3'd1, CMD_DELETE, 16'd300, 16'd2);
    end_test();

    start_test("delete");
    send_spaced(3'd2, CMD_ADD, 16'd800, 16'd20);
    send_spaced(3'd2, CMD_ADD, 16'd700, 16'd9);
    send_spaced(3'd2, CMD_DELETE, 16'd800, 16'd5);
    send_spaced(3'd2, CMD_DELETE, 16'd800, 16'd15);
    send_spaced(3'd2, CMD_DELETE, 16'd999, 16'd1);
    send_spaced(3'd2, CMD_DELETE, 16'd650, 16'd4);
    end_test();

    // Gaps of 0, 1, 2 and 3 cycles hit each forwarding source
    start_test("back_to_back");
    send(3'd3, CMD_ADD, 16'd100, 16'd1);
    send(3'd3, CMD_ADD, 16'd100, 16'd2);
    send(3'd3, CMD_ADD, 16'd120, 16'd3);
    idle(1);
    send(3'd3, CMD_DELETE, 16'd120, 16'd1);
    idle(2);
    send(3'd3, CMD_ADD, 16'd130, 16'd4);
    idle(3);
    send(3'd3, CMD_DELETE, 16'd130, 16'd4);
    for (int i = 0; i < RAND_CYCLES; i++) begin
      if ($urandom_range(3) == 0) begin
        idle(1);
      end else begin
        send_random();
      end
    end
    end_test();

    start_test("clear");
    send_spaced(3'd2, CMD_CLEAR, 16'd0, 16'd0);
    send_spaced(3'd2, CMD_CLEAR, 16'd0, 16'd0);
    send_spaced(3'd6, CMD_CLEAR, 16'd0, 16'd0);
    end_test();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Run limit from the stimulus length
  initial begin
    repeat (CYCLE_LIMIT) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: book_update.f
+incdir+include
hdl/book_pkg.sv
hdl/book_stage_if.sv
hdl/upd_intake.sv
hdl/state_table.sv
hdl/book_forward.sv
hdl/book_exe.sv
hdl/book_writeback.sv
hdl/book_update_top.sv
verification/tb_clkgen.sv
verification/tb_book_update.sv

// File: Bender.yml
package:
  name: book_update

sources:
  - include_dirs:
      - include
    files:
      - hdl/book_pkg.sv
      - hdl/book_stage_if.sv
      - hdl/upd_intake.sv
      - hdl/state_table.sv
      - hdl/book_forward.sv
      - hdl/book_exe.sv
      - hdl/book_writeback.sv
      - hdl/book_update_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_clkgen.sv
      - verification/tb_book_update.sv
